/* logic/TextTerminalPkg.sv */
// Shared geometry, VGA timing, colour defaults and FSM encodings; imported by all terminal RTL
package TextTerminalPkg;

	// Screen size in character cells
	localparam int unsigned Columns = 80;
	localparam int unsigned Rows    = 30;

	// Glyph size in pixels
	localparam int unsigned GlyphWidth  = 8;
	localparam int unsigned GlyphHeight = 16;

	localparam int unsigned CellAddrWidth = 13;		// Even byte holds the character, odd byte the colour
	localparam int unsigned ScreenBytes   = 2 * Columns * Rows;
	localparam int unsigned FontAddrWidth = 11;		// 7-bit code followed by 4-bit glyph line
	localparam FontFile = "include/font_test.mem";

	// 640x480 raster, standard VGA porches and sync widths
	localparam int unsigned HVisible = 640;
	localparam int unsigned HFront   = 16;
	localparam int unsigned HSyncLen = 96;
	localparam int unsigned HBack    = 48;
	localparam int unsigned VVisible = 480;
	localparam int unsigned VFront   = 10;
	localparam int unsigned VSyncLen = 2;
	localparam int unsigned VBack    = 33;
	localparam int unsigned HTotal   = HVisible + HFront + HSyncLen + HBack;
	localparam int unsigned VTotal   = VVisible + VFront + VSyncLen + VBack;
	localparam int unsigned CounterWidth = 10;

	localparam int unsigned FetchLead = 8;			// Fetch runs one cell ahead of the beam

	// Pixel pipeline, counted in clocks from the horizontal counter
	localparam int unsigned OutputDelay = 10;
	localparam int unsigned StageTap    = 2;		// Move fetched glyph into the staging slot
	localparam int unsigned LoadTap     = OutputDelay - 3;	// Shift register load

	// White foreground over black background
	localparam logic [7:0] DefaultColor = 8'b1_111_0_000;

	typedef enum logic [7:0] {
		CodeNewLine   = 8'h0D,
		CodeHome      = 8'h1B,
		CodeBackspace = 8'h7F
	} ControlCodeT;

	typedef enum logic [1:0] {
		WriteIdle,
		WriteChar,
		WriteColor
	} WriteStateT;

	typedef enum logic [2:0] {
		FetchIdle,
		FetchColor,
		FetchFont,
		FetchWait,
		FetchDeliver
	} FetchStateT;

endpackage

/* logic/CommandDecoder.sv */
// Byte stream decoder: moves the cursor, tracks the colour and writes printed cells into screen memory
`timescale 1ns/100ps

module CommandDecoder(
	input  logic Clock,
	input  logic Reset,

	input  logic ByteValid_i,
	input  logic [7:0] ByteData_i,

	output logic WriteEnable_o,
	output logic [TextTerminalPkg::CellAddrWidth-1:0] WriteAddress_o,
	output logic [7:0] WriteData_o,

	output logic [6:0] CursorX_o,
	output logic [4:0] CursorY_o
);
	import TextTerminalPkg::*;

	WriteStateT WriteState;
	logic [7:0] Color;							// Attribute byte for the next printed character
	logic [CellAddrWidth-2:0] CellIndex;
	logic [4:0] RowBelow;
	logic [4:0] RowAbove;

	assign CellIndex = (CellAddrWidth-1)'(CursorY_o * Columns + CursorX_o);

	// Vertical neighbours with wrap over the whole screen
	assign RowBelow = (CursorY_o == 5'(Rows - 1)) ? '0 : CursorY_o + 1'b1;
	assign RowAbove = (CursorY_o == '0) ? 5'(Rows - 1) : CursorY_o - 1'b1;

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			WriteState    <= WriteIdle;
			WriteEnable_o <= 1'b0;
			Color         <= DefaultColor;
			CursorX_o     <= '0;
			CursorY_o     <= '0;
		end else begin
			case (WriteState)
				WriteIdle: begin
					if (ByteValid_i) begin
						case (ByteData_i)
							CodeNewLine: begin
								CursorX_o <= '0;
								CursorY_o <= RowBelow;
							end
							CodeBackspace: begin
								if (CursorX_o == '0) begin
									CursorX_o <= 7'(Columns - 1);	// Back to the end of the row above
									CursorY_o <= RowAbove;
								end else begin
									CursorX_o <= CursorX_o - 1'b1;
								end
							end
							CodeHome: begin
								CursorX_o <= '0;
								CursorY_o <= '0;
							end
							default: begin
								if (ByteData_i[7]) begin
									Color <= ByteData_i;			// Colour byte
								end else begin
									WriteState    <= WriteChar;
									WriteEnable_o <= 1'b1;
								end
							end
						endcase
					end
				end

				WriteChar: WriteState <= WriteColor;	// Character lands in this cycle

				WriteColor: begin
					// Colour lands now, cursor steps on with wrap
					WriteState    <= WriteIdle;
					WriteEnable_o <= 1'b0;
					if (CursorX_o == 7'(Columns - 1)) begin
						CursorX_o <= '0;
						CursorY_o <= RowBelow;
					end else begin
						CursorX_o <= CursorX_o + 1'b1;
					end
				end

				default: WriteState <= WriteIdle;
			endcase
		end
	end

	// Write payload: character at the even address, then colour at the odd one
	always_ff @(posedge Clock) begin
		if (WriteState == WriteIdle) begin
			WriteAddress_o <= {CellIndex, 1'b0};
			WriteData_o    <= ByteData_i;
		end else if (WriteState == WriteChar) begin
			WriteAddress_o <= {CellIndex, 1'b1};
			WriteData_o    <= Color;
		end
	end

endmodule

/* logic/ScreenMemory.sv */
// Character and colour store for all cells, written by the decoder and read by the glyph fetcher
`timescale 1ns/100ps

module ScreenMemory(
	input  logic Clock,
	input  logic Reset,

	input  logic WriteEnable_i,
	input  logic [TextTerminalPkg::CellAddrWidth-1:0] WriteAddress_i,
	input  logic [7:0] WriteData_i,

	input  logic [TextTerminalPkg::CellAddrWidth-1:0] ReadAddress_i,
	output logic [7:0] ReadData_o
);
	import TextTerminalPkg::*;

	logic [7:0] Memory [ScreenBytes];

	// Powers up as blank cells, black on black
	initial begin
		for (int i = 0; i < ScreenBytes; i++)
			Memory[i] = 8'h00;
	end

	always @(posedge Clock) begin
		if (WriteEnable_i)
			Memory[WriteAddress_i] <= WriteData_i;
	end

	// Registered read, old data on a same-address collision
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset)
			ReadData_o <= '0;
		else
			ReadData_o <= Memory[ReadAddress_i];
	end

endmodule

/* logic/FontRom.sv */
// Glyph bitmap ROM, 16 rows of 8 pixels per character code, loaded from the font data file
`timescale 1ns/100ps

module FontRom(
	input  logic Clock,
	input  logic Reset,

	input  logic [TextTerminalPkg::FontAddrWidth-1:0] Address_i,
	output logic [7:0] Data_o
);
	import TextTerminalPkg::*;

	logic [7:0] Table [2**FontAddrWidth];

	// Glyphs that the file does not list stay blank
	initial begin
		for (int i = 0; i < 2**FontAddrWidth; i++)
			Table[i] = 8'h00;
		$readmemh(FontFile, Table);
	end

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset)
			Data_o <= '0;
		else
			Data_o <= Table[Address_i];		// MSB is the leftmost pixel
	end

endmodule

/* logic/RasterTiming.sv */
// VGA raster counters producing sync, blanking, cell boundaries and look-ahead fetch requests
`timescale 1ns/100ps

module RasterTiming(
	input  logic Clock,
	input  logic Reset,

	output logic FetchRequest_o,
	output logic [6:0] FetchColumn_o,
	output logic [4:0] FetchRow_o,
	output logic [3:0] FetchLine_o,

	output logic CellStart_o,
	output logic HSync_o,
	output logic VSync_o,
	output logic Blank_o
);
	import TextTerminalPkg::*;

	logic [CounterWidth-1:0] HCounter;
	logic [CounterWidth-1:0] VCounter;
	logic [CounterWidth-1:0] LeadH;					// Pixel position FetchLead clocks ahead
	logic [CounterWidth-1:0] LeadV;

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			HCounter <= '0;
			VCounter <= '0;
		end else if (HCounter == CounterWidth'(HTotal - 1)) begin
			HCounter <= '0;
			if (VCounter == CounterWidth'(VTotal - 1))
				VCounter <= '0;
			else
				VCounter <= VCounter + 1'b1;
		end else begin
			HCounter <= HCounter + 1'b1;
		end
	end

	// Active-low sync pulses after the front porch
	assign HSync_o = !((HCounter >= HVisible + HFront) &&
		(HCounter < HVisible + HFront + HSyncLen));
	assign VSync_o = !((VCounter >= VVisible + VFront) &&
		(VCounter < VVisible + VFront + VSyncLen));

	assign Blank_o     = (HCounter >= HVisible) || (VCounter >= VVisible);
	assign CellStart_o = (HCounter % GlyphWidth) == 0;

	// Look-ahead position, rolls into the next line near the end of blanking
	always_comb begin
		LeadH = CounterWidth'(HCounter + FetchLead);
		LeadV = VCounter;
		if (LeadH >= HTotal) begin
			LeadH = CounterWidth'(LeadH - HTotal);
			if (VCounter == CounterWidth'(VTotal - 1))
				LeadV = '0;
			else
				LeadV = VCounter + 1'b1;
		end
	end

	assign FetchColumn_o = 7'(LeadH / GlyphWidth);
	assign FetchRow_o    = 5'(LeadV / GlyphHeight);
	assign FetchLine_o   = 4'(LeadV % GlyphHeight);

	// One request per visible cell, FetchLead is a whole cell so boundaries coincide
	assign FetchRequest_o = CellStart_o && (LeadH < HVisible) && (LeadV < VVisible);

endmodule

/* logic/GlyphFetch.sv */
// Reads a cell's character and colour, then its glyph row, and hands the result to the pixel shifter
`timescale 1ns/100ps

module GlyphFetch(
	input  logic Clock,
	input  logic Reset,

	input  logic FetchRequest_i,
	input  logic [6:0] FetchColumn_i,
	input  logic [4:0] FetchRow_i,
	input  logic [3:0] FetchLine_i,

	output logic [TextTerminalPkg::CellAddrWidth-1:0] MemAddress_o,
	input  logic [7:0] MemData_i,

	output logic [TextTerminalPkg::FontAddrWidth-1:0] FontAddress_o,
	input  logic [7:0] FontData_i,

	output logic GlyphValid_o,
	output logic [TextTerminalPkg::GlyphWidth-1:0] GlyphRow_o,
	output logic [2:0] Foreground_o,
	output logic [2:0] Background_o
);
	import TextTerminalPkg::*;

	FetchStateT FetchState;
	logic [CellAddrWidth-2:0] CellIndex;
	logic [3:0] Line;								// Glyph line captured with the request

	assign CellIndex = (CellAddrWidth-1)'(FetchRow_i * Columns + FetchColumn_i);

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			FetchState   <= FetchIdle;
			GlyphValid_o <= 1'b0;
		end else begin
			GlyphValid_o <= 1'b0;
			case (FetchState)
				FetchIdle: begin
					if (FetchRequest_i)
						FetchState <= FetchColor;
				end
				FetchColor:   FetchState <= FetchFont;
				FetchFont:    FetchState <= FetchWait;
				FetchWait:    FetchState <= FetchDeliver;
				FetchDeliver: begin
					GlyphValid_o <= 1'b1;		// Seen five clocks after the request
					FetchState   <= FetchIdle;
				end
				default: FetchState <= FetchIdle;
			endcase
		end
	end

	always_ff @(posedge Clock) begin
		case (FetchState)
			FetchIdle: begin
				if (FetchRequest_i) begin
					MemAddress_o <= {CellIndex, 1'b0};	// Character byte
					Line         <= FetchLine_i;
				end
			end

			FetchColor: MemAddress_o[0] <= 1'b1;		// Colour byte of the same cell

			// Character has arrived, colour follows next cycle
			FetchFont: FontAddress_o <= {MemData_i[6:0], Line};

			FetchDeliver: begin
				GlyphRow_o   <= FontData_i;
				Foreground_o <= MemData_i[6:4];
				Background_o <= MemData_i[2:0];
			end

			default: begin
			end
		endcase
	end

endmodule

/* logic/PixelShifter.sv */
// Serializes glyph rows into RGB pixels and delays sync and blank so all outputs stay aligned
`timescale 1ns/100ps

module PixelShifter(
	input  logic Clock,
	input  logic Reset,

	input  logic GlyphValid_i,
	input  logic [TextTerminalPkg::GlyphWidth-1:0] GlyphRow_i,
	input  logic [2:0] Foreground_i,
	input  logic [2:0] Background_i,

	input  logic CellStart_i,
	input  logic HSync_i,
	input  logic VSync_i,
	input  logic Blank_i,

	output logic [2:0] RGB_o,
	output logic HSync_o,
	output logic VSync_o,
	output logic DataEnable_o
);
	import TextTerminalPkg::*;

	// Bit k holds the raster signal from k+1 clocks ago
	logic [OutputDelay-1:0] HSyncDelay;
	logic [OutputDelay-1:0] VSyncDelay;
	logic [OutputDelay-1:0] BlankDelay;
	logic [LoadTap:0] CellDelay;				// Cell starts are only needed up to the load

	logic [GlyphWidth-1:0] NextRow, StagedRow, ShiftRow;
	logic [2:0] NextFg, NextBg, StagedFg, StagedBg, ShiftFg, ShiftBg;

	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			HSyncDelay <= '1;						// Sync idles high
			VSyncDelay <= '1;
			BlankDelay <= '1;
			CellDelay  <= '0;
		end else begin
			HSyncDelay <= {HSyncDelay[OutputDelay-2:0], HSync_i};
			VSyncDelay <= {VSyncDelay[OutputDelay-2:0], VSync_i};
			BlankDelay <= {BlankDelay[OutputDelay-2:0], Blank_i};
			CellDelay  <= {CellDelay[LoadTap-1:0], CellStart_i};
		end
	end

	assign HSync_o      = HSyncDelay[OutputDelay-1];
	assign VSync_o      = VSyncDelay[OutputDelay-1];
	assign DataEnable_o = !BlankDelay[OutputDelay-1];

	// Glyph path cleared so cells before the first fetch come out black
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			{NextRow, NextFg, NextBg}       <= '0;
			{StagedRow, StagedFg, StagedBg} <= '0;
			{ShiftRow, ShiftFg, ShiftBg}    <= '0;
			RGB_o <= '0;
		end else begin
			if (GlyphValid_i)
				{NextRow, NextFg, NextBg} <= {GlyphRow_i, Foreground_i, Background_i};

			// Staging slot frees the next slot before the following fetch lands
			if (CellDelay[StageTap])
				{StagedRow, StagedFg, StagedBg} <= {NextRow, NextFg, NextBg};

			if (CellDelay[LoadTap])
				{ShiftRow, ShiftFg, ShiftBg} <= {StagedRow, StagedFg, StagedBg};
			else
				ShiftRow <= {ShiftRow[GlyphWidth-2:0], 1'b0};

			// Blank tap is one stage past the load, matching the pixel now at the MSB
			if (BlankDelay[LoadTap+1])
				RGB_o <= '0;
			else
				RGB_o <= ShiftRow[GlyphWidth-1] ? ShiftFg : ShiftBg;
		end
	end

endmodule

/* logic/TextTerminal.sv */
// Top of the byte-fed text terminal: command decoder, screen and font memories and VGA pipeline
`timescale 1ns/100ps

module TextTerminal(
	input  logic Clock,
	input  logic Reset,

	input  logic ByteValid_i,
	input  logic [7:0] ByteData_i,

	output logic [2:0] RGB_o,
	output logic HSync_o,
	output logic VSync_o,
	output logic DataEnable_o,

	output logic [6:0] CursorX_o,
	output logic [4:0] CursorY_o
);
	import TextTerminalPkg::*;

	// Write side
	logic WriteEnable;
	logic [CellAddrWidth-1:0] WriteAddress;
	logic [7:0] WriteData;

	// Read side
	logic [CellAddrWidth-1:0] MemAddress;
	logic [7:0] MemData;
	logic [FontAddrWidth-1:0] FontAddress;
	logic [7:0] FontData;

	logic FetchRequest;
	logic [6:0] FetchColumn;
	logic [4:0] FetchRow;
	logic [3:0] FetchLine;
	logic CellStart, RawHSync, RawVSync, RawBlank;

	logic GlyphValid;
	logic [GlyphWidth-1:0] GlyphRow;
	logic [2:0] Foreground, Background;

	CommandDecoder Decoder(
		.Clock, .Reset,
		.ByteValid_i, .ByteData_i,
		.WriteEnable_o(WriteEnable), .WriteAddress_o(WriteAddress), .WriteData_o(WriteData),
		.CursorX_o, .CursorY_o
	);

	ScreenMemory Screen(
		.Clock, .Reset,
		.WriteEnable_i(WriteEnable), .WriteAddress_i(WriteAddress), .WriteData_i(WriteData),
		.ReadAddress_i(MemAddress), .ReadData_o(MemData)
	);

	FontRom Font(.Clock, .Reset, .Address_i(FontAddress), .Data_o(FontData));

	RasterTiming Timing(
		.Clock, .Reset,
		.FetchRequest_o(FetchRequest), .FetchColumn_o(FetchColumn),
		.FetchRow_o(FetchRow), .FetchLine_o(FetchLine),
		.CellStart_o(CellStart), .HSync_o(RawHSync), .VSync_o(RawVSync), .Blank_o(RawBlank)
	);

	GlyphFetch Fetch(
		.Clock, .Reset,
		.FetchRequest_i(FetchRequest), .FetchColumn_i(FetchColumn),
		.FetchRow_i(FetchRow), .FetchLine_i(FetchLine),
		.MemAddress_o(MemAddress), .MemData_i(MemData),
		.FontAddress_o(FontAddress), .FontData_i(FontData),
		.GlyphValid_o(GlyphValid), .GlyphRow_o(GlyphRow),
		.Foreground_o(Foreground), .Background_o(Background)
	);

	PixelShifter Shifter(
		.Clock, .Reset,
		.GlyphValid_i(GlyphValid), .GlyphRow_i(GlyphRow),
		.Foreground_i(Foreground), .Background_i(Background),
		.CellStart_i(CellStart), .HSync_i(RawHSync), .VSync_i(RawVSync), .Blank_i(RawBlank),
		.RGB_o, .HSync_o, .VSync_o, .DataEnable_o
	);

endmodule

/* verif/TextTerminalTb.sv */
// Testbench for the text terminal: replays the trace file and checks cursor moves and frame pixels
`timescale 1ns/100ps

module TextTerminalTb;

	localparam int Width = 640;			// Visible pixels per line
	localparam int Height = 480;		// Visible lines per frame
	localparam int CellWidth = 8;
	localparam int CellHeight = 16;
	localparam int LineLimit = 800;
	localparam int HFrontPorch = 16;
	localparam int HSyncWidth = 96;
	localparam int VFrontPorch = 10;	// Lines between the last visible line and the VSync pulse
	localparam int FrameTimeout = 500000;

	typedef struct packed {
		logic [6:0] column;
		logic [4:0] row;
		logic [3:0] line;
		logic [7:0] pixels;
		logic [2:0] fg;
		logic [2:0] bg;
	} GlyphExpectT;

	logic Clock;
	logic Reset;
	logic ByteValid_i;
	logic [7:0] ByteData_i;
	logic [2:0] RGB_o;
	logic HSync_o;
	logic VSync_o;
	logic DataEnable_o;
	logic [6:0] CursorX_o;
	logic [4:0] CursorY_o;

	logic [2:0] Frame [Height][Width];		// Last captured visible frame
	GlyphExpectT Pending[$];
	int ChecksRun;

	TextTerminal UUT(
		.Clock, .Reset,
		.ByteValid_i, .ByteData_i,
		.RGB_o, .HSync_o, .VSync_o, .DataEnable_o,
		.CursorX_o, .CursorY_o
	);

	initial Clock = 1'b0;
	always #50 Clock = !Clock;

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
		ChecksRun++;
		if (actual !== expected)
			abortRun($sformatf("Error %s: got %0h, expected %0h", name, actual, expected));
	endtask

	// Pixel k of a glyph row, leftmost pixel is bit 7
	function automatic logic [2:0] pixelColor(input logic [7:0] pixels, input int k,
		input logic [2:0] fg, input logic [2:0] bg);
		return pixels[7 - k] ? fg : bg;
	endfunction

	task automatic sendByte(input logic [7:0] value, input logic [6:0] expX, input logic [4:0] expY);
		int gap;
		gap = 4 + ($urandom % 4);		// Strobes stay at least four cycles apart
		@(posedge Clock);
		ByteValid_i <= 1'b1;
		ByteData_i  <= value;
		@(posedge Clock);
		ByteValid_i <= 1'b0;
		repeat (3) @(posedge Clock);
		@(negedge Clock);
		check("CursorX_o", CursorX_o, expX);
		check("CursorY_o", CursorY_o, expY);
		repeat (gap - 4) @(posedge Clock);
	endtask

	task automatic waitVSyncFall();
		int cycles;
		logic previous;
		logic found;
		previous = 1'b0;				// A high sample must come first
		found = 1'b0;
		for (cycles = 0; cycles < FrameTimeout && !found; cycles++) begin
			@(negedge Clock);
			found = previous && !VSync_o;
			previous = VSync_o;
		end
		if (!found)
			abortRun("VSync_o never fell, the frame never arrived");
	endtask

	// Records one visible frame, checking line length, line count and sync placement on the way
	task automatic captureFrame();
		int line;
		int pixels;
		int waited;
		int extra;
		int syncLow;
		int beforeSync;
		waitVSyncFall();
		for (line = 0; line < Height; line++) begin
			waited = 0;
			syncLow = 0;
			beforeSync = 0;
			while (!DataEnable_o && waited < FrameTimeout) begin
				if (!HSync_o)
					syncLow++;
				else if (syncLow == 0)
					beforeSync++;
				@(negedge Clock);
				waited++;
			end
			if (!DataEnable_o)
				abortRun("DataEnable_o never rose for the next visible line");

			// Horizontal blanking between two visible lines
			if (line > 0) begin
				check("HSync_o cycles before the pulse", beforeSync, HFrontPorch);
				check("HSync_o pulse width", syncLow, HSyncWidth);
				check("DataEnable_o low cycles between lines", waited, LineLimit - Width);
			end

			pixels = 0;
			while (DataEnable_o && pixels < LineLimit) begin
				if (pixels < Width)
					Frame[line][pixels] = RGB_o;
				check("HSync_o during a visible pixel", HSync_o, 1'b1);
				pixels++;
				@(negedge Clock);
			end
			check($sformatf("DataEnable_o pixels on line %0d", line), pixels, Width);
		end

		// Front porch up to the next sync must stay dark
		extra = 0;
		waited = 0;
		while (VSync_o && waited < FrameTimeout) begin
			if (DataEnable_o)
				extra++;
			@(negedge Clock);
			waited++;
		end
		if (VSync_o)
			abortRun("VSync_o never fell after the visible lines");
		check("DataEnable_o cycles after the last line", extra, 0);
		check("VSync_o cycles before the pulse", waited,
			(LineLimit - Width) + VFrontPorch * LineLimit);
	endtask

	task automatic checkPendingGlyphs();
		GlyphExpectT entry;
		int y;
		int x;
		if (Pending.size() > 0) begin
			captureFrame();
			foreach (Pending[i]) begin
				entry = Pending[i];
				y = entry.row * CellHeight + entry.line;
				for (int k = 0; k < CellWidth; k++) begin
					x = entry.column * CellWidth + k;
					check($sformatf("RGB_o cell %0d,%0d line %0d pixel %0d",
						entry.column, entry.row, entry.line, k),
						Frame[y][x], pixelColor(entry.pixels, k, entry.fg, entry.bg));
				end
			end
			Pending.delete();
		end
	endtask

	int unsigned Seeded;
	int TraceFile;
	int Character;
	int Fields;
	logic [31:0] Value [6];
	int NonZero;
	logic TraceDone;

	initial begin
		Seeded = $urandom(32'h6848b8f4);
		ChecksRun = 0;
		Reset = 1'b0;
		ByteValid_i = 1'b0;
		ByteData_i = 8'h00;
		repeat (10) @(posedge Clock);
		Reset <= 1'b1;

		// Reset state, then a frame of blank cells
		@(negedge Clock);
		check("CursorX_o", CursorX_o, 0);
		check("CursorY_o", CursorY_o, 0);
		captureFrame();
		NonZero = 0;
		foreach (Frame[y, x])
			if (Frame[y][x] !== 3'd0)
				NonZero++;
		check("RGB_o nonzero pixels in the blank frame", NonZero, 0);

		TraceFile = $fopen("verif/terminal_trace.txt", "r");
		if (TraceFile == 0)
			abortRun("Could not open the trace file verif/terminal_trace.txt");

		// One character decides the line kind, whitespace between lines is skipped
		TraceDone = 1'b0;
		while (!TraceDone) begin
			Character = $fgetc(TraceFile);
			if (Character == -1) begin
				TraceDone = 1'b1;
			end else if (Character == "#") begin
				while (Character != "\n" && Character != -1)
					Character = $fgetc(TraceFile);
			end else if (Character == "B") begin
				Fields = $fscanf(TraceFile, "%h %h %h", Value[0], Value[1], Value[2]);
				if (Fields != 3)
					abortRun("A byte line in the trace is malformed");
				checkPendingGlyphs();			// Earlier glyph rows are judged before new writes
				sendByte(Value[0][7:0], Value[1][6:0], Value[2][4:0]);
			end else if (Character == "P") begin
				Fields = $fscanf(TraceFile, "%h %h %h %h %h %h",
					Value[0], Value[1], Value[2], Value[3], Value[4], Value[5]);
				if (Fields != 6)
					abortRun("A pixel line in the trace is malformed");
				Pending.push_back('{Value[0][6:0], Value[1][4:0], Value[2][3:0],
					Value[3][7:0], Value[4][2:0], Value[5][2:0]});
			end
		end
		$fclose(TraceFile);
		checkPendingGlyphs();

		if (ChecksRun == 0) begin
			abortRun("The trace produced no checks");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

/* include/font_test.mem */
// Test font for the terminal, 16 rows per glyph at code*16+line, MSB is the leftmost pixel
// Only space, '0' and 'A' are listed here, every other glyph reads as blank
@200
00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00
@300
00
00
7C
C6
C6
CE
DE
F6
E6
C6
C6
7C
00
00
00
00
@410
00
00
10
38
6C
C6
C6
FE
C6
C6
C6
C6
00
00
00
00

/* verif/terminal_trace.txt */
# B byte cursorX cursorY : strobe one byte, then expect the cursor (hex)
# P column row line pixels fg bg : expected glyph row at a cell, fg and bg as 3-bit colours (hex)
B 41 01 00
B 30 02 00
P 00 00 03 38 7 0
P 00 00 07 FE 7 0
P 01 00 05 CE 7 0
P 02 00 05 00 0 0
B A4 02 00
B 41 03 00
P 02 00 07 FE 2 4
P 02 00 00 00 2 4
P 00 00 07 FE 7 0
B 20 04 00
B 20 05 00
B 0D 00 01
B 7F 4F 00
B 30 00 01
B 1B 00 00
B 7F 4F 1D
B 41 00 00
P 4F 00 06 DE 2 4
P 4F 1D 07 FE 2 4
B 7F 4F 1D
B 30 00 00
P 4F 1D 05 CE 2 4
P 04 00 08 00 2 4

/* TextTerminal.f */
logic/TextTerminalPkg.sv
logic/CommandDecoder.sv
logic/ScreenMemory.sv
logic/FontRom.sv
logic/RasterTiming.sv
logic/GlyphFetch.sv
logic/PixelShifter.sv
logic/TextTerminal.sv
verif/TextTerminalTb.sv

/* Bender.yml */
package:
  name: text_terminal

dependencies: {}

sources:
  - files:
      - logic/TextTerminalPkg.sv
      - logic/CommandDecoder.sv
      - logic/ScreenMemory.sv
      - logic/FontRom.sv
      - logic/RasterTiming.sv
      - logic/GlyphFetch.sv
      - logic/PixelShifter.sv
      - logic/TextTerminal.sv
  - target: test
    files:
      - verif/TextTerminalTb.sv
